/* design/console_config.svh */
`ifndef CONSOLE_CONFIG_SVH
`define CONSOLE_CONFIG_SVH

// Datapath widths
`define CON_DATA_W      8
`define CON_NUM_W       32
`define CON_CNT_W       16
`define CON_DIGITS      5

// Prompt lengths in characters
`define CON_LEN_ADDR    14
`define CON_LEN_LEN     13
`define CON_LEN_LEFT    5

// ASCII codes
`define CON_ASCII_CR    8'h0D
`define CON_ASCII_LF    8'h0A
`define CON_ASCII_ZERO  8'h30

`endif

/* design/console_pkg.sv */
`include "console_config.svh"

package console_pkg;

  // Commands from the host-side controller
  typedef enum logic [3:0]
  {
    OP_ASK_ADDR = 4'h1,
    OP_ASK_LEN  = 4'h2,
    OP_NEW_LINE = 4'h3,
    OP_READ_HEX = 4'h4,
    OP_BUFFER   = 4'h5,
    OP_REPORT   = 4'h6
  } opcode_e;

  typedef enum logic [2:0]
  {
    MSG_ADDR,
    MSG_LEN,
    MSG_CRLF,
    MSG_LEFT,
    MSG_ECHO,
    MSG_DIGITS
  } msg_id_e;

  typedef enum logic [2:0]
  {
    S_IDLE,
    S_MSG_START,
    S_MSG_WAIT,
    S_HEX_RX,
    S_BUF,
    S_BCD_START,
    S_BCD_WAIT,
    S_DONE
  } seq_state_e;

  // Transmit loop of the message sender
  typedef enum logic [1:0]
  {
    TX_IDLE,
    TX_SEND,
    TX_WAIT,
    TX_NEXT
  } snd_state_e;

  typedef struct packed
  {
    opcode_e               op;
    logic [`CON_CNT_W-1:0] count;
  } cmd_t;

  typedef struct packed
  {
    logic                   dv;
    logic [`CON_DATA_W-1:0] data;
  } uart_rx_t;

  typedef struct packed
  {
    logic                   start;
    msg_id_e                id;
    logic [`CON_DATA_W-1:0] echo;   // Only for MSG_ECHO
  } msg_req_t;

endpackage

/* design/msg_rom.sv */
`timescale 1ns/1ns

`include "console_config.svh"

module msg_rom
(
  input  console_pkg::msg_id_e      i_id,
  input  logic [4:0]                i_index,
  output logic [`CON_DATA_W-1:0]    o_char,
  output logic                      o_last
);

  localparam logic [`CON_DATA_W*`CON_LEN_ADDR-1:0] txt_addr = "Address (hex):";
  localparam logic [`CON_DATA_W*`CON_LEN_LEN-1:0]  txt_len  = "Length (hex):";
  localparam logic [`CON_DATA_W*`CON_LEN_LEFT-1:0] txt_left = "Left:";
  localparam logic [2*`CON_DATA_W-1:0]             txt_crlf = {`CON_ASCII_CR, `CON_ASCII_LF};

  logic [7:0]                                ofs;
  logic [`CON_DATA_W*`CON_LEN_ADDR-1:0]      addr_shl;
  logic [`CON_DATA_W*`CON_LEN_LEN-1:0]       len_shl;
  logic [`CON_DATA_W*`CON_LEN_LEFT-1:0]      left_shl;
  logic [2*`CON_DATA_W-1:0]                  crlf_shl;

  assign ofs = {i_index, 3'b000};

  // First character sits in the top byte of each string
  always_comb
  begin
    addr_shl = txt_addr << ofs;
    len_shl  = txt_len << ofs;
    left_shl = txt_left << ofs;
    crlf_shl = txt_crlf << ofs;
    case (i_id)
      console_pkg::MSG_ADDR:
      begin
        o_char = addr_shl[`CON_DATA_W*`CON_LEN_ADDR-1 -: `CON_DATA_W];
        o_last = (i_index == 5'(`CON_LEN_ADDR - 1));
      end
      console_pkg::MSG_LEN:
      begin
        o_char = len_shl[`CON_DATA_W*`CON_LEN_LEN-1 -: `CON_DATA_W];
        o_last = (i_index == 5'(`CON_LEN_LEN - 1));
      end
      console_pkg::MSG_LEFT:
      begin
        o_char = left_shl[`CON_DATA_W*`CON_LEN_LEFT-1 -: `CON_DATA_W];
        o_last = (i_index == 5'(`CON_LEN_LEFT - 1));
      end
      console_pkg::MSG_CRLF:
      begin
        o_char = crlf_shl[2*`CON_DATA_W-1 -: `CON_DATA_W];
        o_last = (i_index == 5'd1);
      end
      default:
      begin
        o_char = '0;   // Echo and digits are built in the sender
        o_last = 1'b0;
      end
    endcase
  end

endmodule

/* design/msg_sender.sv */
`timescale 1ns/1ns

`include "console_config.svh"

module msg_sender
(
  input  logic                      clk,
  input  logic                      rst,
  input  console_pkg::msg_req_t     i_msg,
  output logic                      o_msg_done,
  input  logic [4*`CON_DIGITS-1:0]  i_digits,
  output logic                      o_tx_dv,
  output logic [`CON_DATA_W-1:0]    o_tx_byte,
  input  logic                      i_tx_done
);

  console_pkg::snd_state_e    state;
  console_pkg::msg_id_e       id_q;
  logic [`CON_DATA_W-1:0]     echo_q;
  logic [4:0]                 idx_q;
  logic [4:0]                 len_q;
  logic [`CON_DATA_W-1:0]     rom_char;
  logic                       rom_last;
  logic [4*`CON_DIGITS-1:0]   digits_shl;
  logic                       from_rom;
  logic                       last_byte;

  msg_rom u_msg_rom
  (
    .i_id    (id_q),
    .i_index (idx_q),
    .o_char  (rom_char),
    .o_last  (rom_last)
  );

  assign from_rom   = (id_q != console_pkg::MSG_ECHO) && (id_q != console_pkg::MSG_DIGITS);
  assign last_byte  = from_rom ? rom_last : (idx_q == len_q - 5'd1);
  assign digits_shl = i_digits << {idx_q, 2'b00};  // Current digit lands on top

  always_comb
  begin
    case (id_q)
      console_pkg::MSG_ECHO:
        o_tx_byte = echo_q;
      console_pkg::MSG_DIGITS:
        o_tx_byte = `CON_ASCII_ZERO + {4'h0, digits_shl[4*`CON_DIGITS-1 -: 4]};
      default:
        o_tx_byte = rom_char;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Byte loop: present, wait for done, advance
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= console_pkg::TX_IDLE;
    else
    begin
      case (state)
        console_pkg::TX_IDLE:
        begin
          if (i_msg.start)
          begin
            id_q   <= i_msg.id;
            echo_q <= i_msg.echo;
            idx_q  <= '0;
            if (i_msg.id == console_pkg::MSG_DIGITS)
              len_q <= 5'(`CON_DIGITS);
            else
              len_q <= 5'd1;
            state  <= console_pkg::TX_SEND;
          end
        end
        console_pkg::TX_SEND:
          state <= console_pkg::TX_WAIT;
        console_pkg::TX_WAIT:
        begin
          if (i_tx_done)
            state <= last_byte ? console_pkg::TX_IDLE : console_pkg::TX_NEXT;
        end
        console_pkg::TX_NEXT:
        begin
          idx_q <= idx_q + 5'd1;
          state <= console_pkg::TX_SEND;
        end
        default:
          state <= console_pkg::TX_IDLE;
      endcase
    end
  end

  assign o_tx_dv    = (state == console_pkg::TX_SEND);
  assign o_msg_done = (state == console_pkg::TX_WAIT) && i_tx_done && last_byte;

endmodule

/* design/bcd_digit_cell.sv */
`timescale 1ns/1ns

module bcd_digit_cell
(
  input  logic        clk,
  input  logic        rst,
  input  logic        i_clear,
  input  logic        i_shift,
  input  logic        i_carry_in,
  output logic        o_carry_out,
  output logic [3:0]  o_digit
);

  logic [3:0] digit_q;
  logic [3:0] adj;

  // Add 3 ahead of the shift so the doubled value stays decimal
  assign adj = (digit_q > 4'd4) ? digit_q + 4'd3 : digit_q;

  always_ff @(posedge clk)
  begin
    if (rst)
      digit_q <= '0;
    else if (i_clear)
      digit_q <= '0;
    else if (i_shift)
      digit_q <= {adj[2:0], i_carry_in};
  end

  assign o_carry_out = adj[3];  // Top bit moves to the next digit
  assign o_digit     = digit_q;

endmodule

/* design/bcd_shift_ctrl.sv */
`timescale 1ns/1ns

`include "console_config.svh"

module bcd_shift_ctrl
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_start,
  input  logic [`CON_CNT_W-1:0]   i_value,
  output logic                    o_clear,
  output logic                    o_shift,
  output logic                    o_bit,
  output logic                    o_ready
);

  localparam int cnt_bits = $clog2(`CON_CNT_W);

  logic [`CON_CNT_W-1:0]  value_q;
  logic [cnt_bits-1:0]    shift_cnt;
  logic                   busy_q;
  logic                   ready_q;

  //////////////////////////////////////////////////////////////////////
  // One load cycle then one shift per bit
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q    <= 1'b0;
      ready_q   <= 1'b0;
      shift_cnt <= '0;
    end
    else
    begin
      ready_q <= 1'b0;
      if (i_start)
      begin
        busy_q    <= 1'b1;
        shift_cnt <= '0;
      end
      else if (busy_q)
      begin
        shift_cnt <= shift_cnt + 1'b1;
        if (shift_cnt == cnt_bits'(`CON_CNT_W - 1))
        begin
          busy_q  <= 1'b0;
          ready_q <= 1'b1;  // Digits settle on this last shift
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_start)
      value_q <= i_value;
    else if (busy_q)
      value_q <= value_q << 1;
  end

  assign o_clear = i_start;
  assign o_shift = busy_q;
  assign o_bit   = value_q[`CON_CNT_W-1];  // MSB first
  assign o_ready = ready_q;

endmodule

/* design/console_seq.sv */
`timescale 1ns/1ns

`include "console_config.svh"

module console_seq
(
  input  logic                    clk,
  input  logic                    rst,
  input  console_pkg::cmd_t       i_cmd,
  input  logic                    i_cmd_valid,
  output logic                    o_done,
  output logic [`CON_NUM_W-1:0]   o_number,
  input  console_pkg::uart_rx_t   i_rx,
  output logic                    o_buf_wren,
  output console_pkg::msg_req_t   o_msg,
  input  logic                    i_msg_done,
  output logic                    o_bcd_start,
  output logic [`CON_CNT_W-1:0]   o_bcd_value,
  input  logic                    i_bcd_ready
);

  console_pkg::seq_state_e  state;
  console_pkg::opcode_e     op_q;
  console_pkg::msg_id_e     msg_id_q;
  logic [`CON_DATA_W-1:0]   echo_q;
  logic [`CON_CNT_W-1:0]    cnt_q;
  logic [`CON_NUM_W-1:0]    num_q;
  logic                     bcd_ready_q;
  logic                     hex_ok;
  logic [3:0]               hex_nib;

  // Hex digit decode, both cases map to the same nibble
  always_comb
  begin
    hex_ok  = 1'b1;
    hex_nib = i_rx.data[3:0];
    if ((i_rx.data >= "A" && i_rx.data <= "F") || (i_rx.data >= "a" && i_rx.data <= "f"))
      hex_nib = i_rx.data[3:0] + 4'd9;
    else if (!(i_rx.data >= "0" && i_rx.data <= "9"))
      hex_ok = 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= console_pkg::S_IDLE;
      num_q <= '0;
    end
    else
    begin
      case (state)
        console_pkg::S_IDLE:
        begin
          if (i_cmd_valid)
          begin
            op_q  <= i_cmd.op;
            cnt_q <= i_cmd.count;
            case (i_cmd.op)
              console_pkg::OP_ASK_ADDR:
              begin
                msg_id_q <= console_pkg::MSG_ADDR;
                state    <= console_pkg::S_MSG_START;
              end
              console_pkg::OP_ASK_LEN:
              begin
                msg_id_q <= console_pkg::MSG_LEN;
                state    <= console_pkg::S_MSG_START;
              end
              console_pkg::OP_NEW_LINE, console_pkg::OP_REPORT:
              begin
                msg_id_q <= console_pkg::MSG_CRLF;
                state    <= console_pkg::S_MSG_START;
              end
              console_pkg::OP_READ_HEX:
              begin
                num_q <= '0;
                state <= console_pkg::S_HEX_RX;
              end
              console_pkg::OP_BUFFER:
              begin
                if (i_cmd.count == '0)
                  state <= console_pkg::S_DONE;  // Nothing to receive
                else
                  state <= console_pkg::S_BUF;
              end
              default:
                state <= console_pkg::S_IDLE;
            endcase
          end
        end
        console_pkg::S_MSG_START:
          state <= console_pkg::S_MSG_WAIT;
        console_pkg::S_MSG_WAIT:
        begin
          if (i_msg_done)
          begin
            if (op_q == console_pkg::OP_READ_HEX)
              state <= console_pkg::S_HEX_RX;  // Echo sent, next key
            else if (op_q == console_pkg::OP_REPORT && msg_id_q == console_pkg::MSG_CRLF)
            begin
              msg_id_q <= console_pkg::MSG_LEFT;
              state    <= console_pkg::S_BCD_START;
            end
            else if (op_q == console_pkg::OP_REPORT && msg_id_q == console_pkg::MSG_LEFT)
              state <= console_pkg::S_BCD_WAIT;
            else
              state <= console_pkg::S_DONE;
          end
        end
        console_pkg::S_HEX_RX:
        begin
          if (i_rx.dv)
          begin
            if (hex_ok)
            begin
              num_q    <= {num_q[`CON_NUM_W-5:0], hex_nib};
              echo_q   <= i_rx.data;
              msg_id_q <= console_pkg::MSG_ECHO;
              state    <= console_pkg::S_MSG_START;
            end
            else if (i_rx.data == `CON_ASCII_CR)
              state <= console_pkg::S_DONE;
          end
        end
        console_pkg::S_BUF:
        begin
          if (i_rx.dv)
          begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == `CON_CNT_W'(1))
              state <= console_pkg::S_DONE;
          end
        end
        console_pkg::S_BCD_START:
          state <= console_pkg::S_MSG_START;  // "Left:" goes out during conversion
        console_pkg::S_BCD_WAIT:
        begin
          if (bcd_ready_q)
          begin
            msg_id_q <= console_pkg::MSG_DIGITS;
            state    <= console_pkg::S_MSG_START;
          end
        end
        default:
          state <= console_pkg::S_IDLE;
      endcase
    end
  end

  // Conversion may finish before the prompt does
  always_ff @(posedge clk)
  begin
    if (rst)
      bcd_ready_q <= 1'b0;
    else if (state == console_pkg::S_BCD_START)
      bcd_ready_q <= 1'b0;
    else if (i_bcd_ready)
      bcd_ready_q <= 1'b1;
  end

  assign o_done      = (state == console_pkg::S_DONE);
  assign o_buf_wren  = (state == console_pkg::S_BUF) && i_rx.dv;
  assign o_bcd_start = (state == console_pkg::S_BCD_START);
  assign o_bcd_value = cnt_q;
  assign o_number    = num_q;

  always_comb
  begin
    o_msg.start = (state == console_pkg::S_MSG_START);
    o_msg.id    = msg_id_q;
    o_msg.echo  = echo_q;
  end

endmodule

/* design/uart_console.sv */
`timescale 1ns/1ns

`include "console_config.svh"

module uart_console
(
  input  logic                    clk,
  input  logic                    rst,
  input  console_pkg::cmd_t       i_cmd,
  input  logic                    i_cmd_valid,
  output logic                    o_done,
  output logic [`CON_NUM_W-1:0]   o_number,
  input  console_pkg::uart_rx_t   i_rx,
  output logic                    o_buf_wren,
  output logic                    o_tx_dv,
  output logic [`CON_DATA_W-1:0]  o_tx_byte,
  input  logic                    i_tx_done
);

  console_pkg::msg_req_t      msg_req;
  logic                       msg_done;
  logic                       bcd_start;
  logic                       bcd_ready;
  logic                       bcd_clear;
  logic                       bcd_shift;
  logic [`CON_CNT_W-1:0]      bcd_value;
  logic [`CON_DIGITS:0]       bcd_chain;   // Entry 0 is the serial bit
  logic [4*`CON_DIGITS-1:0]   digits;

  console_seq u_console_seq
  (
    .clk         (clk),
    .rst         (rst),
    .i_cmd       (i_cmd),
    .i_cmd_valid (i_cmd_valid),
    .o_done      (o_done),
    .o_number    (o_number),
    .i_rx        (i_rx),
    .o_buf_wren  (o_buf_wren),
    .o_msg       (msg_req),
    .i_msg_done  (msg_done),
    .o_bcd_start (bcd_start),
    .o_bcd_value (bcd_value),
    .i_bcd_ready (bcd_ready)
  );

  msg_sender u_msg_sender
  (
    .clk        (clk),
    .rst        (rst),
    .i_msg      (msg_req),
    .o_msg_done (msg_done),
    .i_digits   (digits),
    .o_tx_dv    (o_tx_dv),
    .o_tx_byte  (o_tx_byte),
    .i_tx_done  (i_tx_done)
  );

  bcd_shift_ctrl u_bcd_shift_ctrl
  (
    .clk     (clk),
    .rst     (rst),
    .i_start (bcd_start),
    .i_value (bcd_value),
    .o_clear (bcd_clear),
    .o_shift (bcd_shift),
    .o_bit   (bcd_chain[0]),
    .o_ready (bcd_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Decimal digit chain, cell 0 is the units digit
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < `CON_DIGITS; g++)
  begin : g_digit
    bcd_digit_cell u_cell
    (
      .clk         (clk),
      .rst         (rst),
      .i_clear     (bcd_clear),
      .i_shift     (bcd_shift),
      .i_carry_in  (bcd_chain[g]),
      .o_carry_out (bcd_chain[g+1]),
      .o_digit     (digits[4*g +: 4])
    );
  end

endmodule

/* verif/uart_console_props.sv */
`timescale 1ns/1ns

module uart_console_props
(
  input logic                   clk,
  input logic                   rst,
  input console_pkg::cmd_t      i_cmd,
  input logic                   i_cmd_valid,
  input console_pkg::uart_rx_t  i_rx,
  input logic                   o_tx_dv,
  input logic                   i_tx_done,
  input logic                   o_done,
  input logic                   o_buf_wren
);

  logic cmd_open;
  logic buf_open;
  logic tx_pending;

  // Command and transmit handshakes as seen on the pins
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cmd_open   <= 1'b0;
      buf_open   <= 1'b0;
      tx_pending <= 1'b0;
    end
    else
    begin
      if (o_done)
      begin
        cmd_open <= 1'b0;
        buf_open <= 1'b0;
      end
      else if (!cmd_open && i_cmd_valid)
      begin
        cmd_open <= 1'b1;
        buf_open <= (i_cmd.op == console_pkg::OP_BUFFER);
      end
      if (o_tx_dv)
        tx_pending <= 1'b1;
      else if (i_tx_done)
        tx_pending <= 1'b0;  // Transmitter free again
    end
  end

  a_tx_dv_pulse: assert property (@(posedge clk) disable iff (rst) o_tx_dv |-> !tx_pending)
    else $error("o_tx_dv came before i_tx_done of the previous byte");

  // Closes the command, so a second cycle finds it closed
  a_done_pulse: assert property (@(posedge clk) disable iff (rst) o_done |-> cmd_open)
    else $error("o_done without an open command or longer than one cycle");

  a_wren_rx: assert property (@(posedge clk) disable iff (rst)
                              o_buf_wren |-> i_rx.dv && buf_open)
    else $error("o_buf_wren outside a received byte of a buffer command");

endmodule

/* verif/uart_console_tb.sv */
`timescale 1ns/1ns

`include "console_config.svh"

module uart_console_tb;

  localparam int num_cmds    = 200;
  localparam int cycle_limit = num_cmds * 400;

  logic                     clk;
  logic                     rst;
  console_pkg::cmd_t        i_cmd;
  logic                     i_cmd_valid;
  logic                     o_done;
  logic [`CON_NUM_W-1:0]    o_number;
  console_pkg::uart_rx_t    i_rx;
  logic                     o_buf_wren;
  logic                     o_tx_dv;
  logic [`CON_DATA_W-1:0]   o_tx_byte;
  logic                     i_tx_done = 1'b0;

  logic [15:0]  stim_lfsr = 16'd79;
  logic [15:0]  tx_lfsr   = 16'd79;
  logic [2:0]   tx_wait;
  logic         tx_busy;
  int           tx_early;
  int           tx_cnt;
  int           done_cnt;
  int           wren_cnt;
  int           cycle_cnt;
  int           checks;
  int           errors;
  int           got_rd;
  logic [7:0]   got_q[$];
  logic [7:0]   exp_q[$];
  logic [31:0]  model_num;

  uart_console i_uart_console
  (
    .clk         (clk),
    .rst         (rst),
    .i_cmd       (i_cmd),
    .i_cmd_valid (i_cmd_valid),
    .o_done      (o_done),
    .o_number    (o_number),
    .i_rx        (i_rx),
    .o_buf_wren  (o_buf_wren),
    .o_tx_dv     (o_tx_dv),
    .o_tx_byte   (o_tx_byte),
    .i_tx_done   (i_tx_done)
  );

  bind uart_console uart_console_props u_props
  (
    .clk         (clk),
    .rst         (rst),
    .i_cmd       (i_cmd),
    .i_cmd_valid (i_cmd_valid),
    .i_rx        (i_rx),
    .o_tx_dv     (o_tx_dv),
    .i_tx_done   (i_tx_done),
    .o_done      (o_done),
    .o_buf_wren  (o_buf_wren)
  );

  always #5 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [15:0] take_bits(inout logic [15:0] st, input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v  = {v[14:0], st[15]};
      st = lfsr_next(st);
    end
    return v;
  endfunction

  // Bit 4 flags a hex digit
  function automatic logic [4:0] hex_nibble(input logic [7:0] c);
    if (c >= "0" && c <= "9")
      return {1'b1, 4'(c - "0")};
    if (c >= "A" && c <= "F")
      return {1'b1, 4'(c - "A" + 8'd10)};
    if (c >= "a" && c <= "f")
      return {1'b1, 4'(c - "a" + 8'd10)};
    return 5'h00;
  endfunction

  function automatic console_pkg::opcode_e op_from(input int sel);
    case (sel % 6)
      0: return console_pkg::OP_ASK_ADDR;
      1: return console_pkg::OP_ASK_LEN;
      2: return console_pkg::OP_NEW_LINE;
      3: return console_pkg::OP_READ_HEX;
      4: return console_pkg::OP_BUFFER;
      default: return console_pkg::OP_REPORT;
    endcase
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s (got %0h, expected %0h)", $time, msg, got, exp);
    end
  endtask

  task automatic expect_text(input string s);
    for (int i = 0; i < s.len(); i++)
      exp_q.push_back(s[i]);
  endtask

  // Second command lands while the first is still sending
  task automatic send_cmd(input console_pkg::opcode_e op, input logic [15:0] count,
                          input logic junk);
    logic [15:0] r;
    i_cmd.op    <= op;
    i_cmd.count <= count;
    i_cmd_valid <= 1'b1;
    @(posedge clk);
    i_cmd_valid <= 1'b0;
    if (junk)
    begin
      @(posedge clk);
      r = take_bits(stim_lfsr, 16);
      i_cmd.op    <= op_from(int'(r[15:13]));
      i_cmd.count <= r;
      i_cmd_valid <= 1'b1;
      @(posedge clk);
      i_cmd_valid <= 1'b0;
    end
  endtask

  task automatic send_rx(input logic [7:0] b);
    i_rx.data <= b;
    i_rx.dv   <= 1'b1;
    @(posedge clk);
    i_rx.dv   <= 1'b0;
  endtask

  task automatic finish_cmd(input int n, input int wren_exp, input int wren_start);
    int got_n;
    got_n = got_q.size() - got_rd;
    check_value(got_n, exp_q.size(), $sformatf("cmd %0d tx byte count", n));
    for (int i = 0; i < exp_q.size() && i < got_n; i++)
      check_value(got_q[got_rd + i], exp_q[i], $sformatf("cmd %0d tx byte %0d", n, i));
    got_rd = got_q.size();
    exp_q.delete();
    check_value(wren_cnt - wren_start, wren_exp, $sformatf("cmd %0d wren strobes", n));
    check_value(o_number, model_num, $sformatf("cmd %0d number", n));
    check_value(tx_early, 0, "byte sent before i_tx_done");
  endtask

  //////////////////////////////////////////////////////////////////////
  // One random command and its expected response
  //////////////////////////////////////////////////////////////////////

  task automatic run_cmd(input int n);
    console_pkg::opcode_e op;
    logic [15:0]          count;
    logic [7:0]           b;
    logic [4:0]           nib;
    int                   done_start;
    int                   wren_start;
    int                   wren_exp;
    int                   keys;
    int                   t0;
    int                   div;
    string                hex_chars;
    hex_chars  = "0123456789ABCDEFabcdef";
    op         = (n < 6) ? op_from(n) : op_from(int'(take_bits(stim_lfsr, 3)));
    done_start = done_cnt;
    wren_start = wren_cnt;
    wren_exp   = 0;
    case (op)
      console_pkg::OP_ASK_ADDR:
      begin
        expect_text("Address (hex):");
        send_cmd(op, '0, 1'b1);
      end
      console_pkg::OP_ASK_LEN:
      begin
        expect_text("Length (hex):");
        send_cmd(op, '0, 1'b1);
      end
      console_pkg::OP_NEW_LINE:
      begin
        exp_q.push_back(`CON_ASCII_CR);
        exp_q.push_back(`CON_ASCII_LF);
        send_cmd(op, '0, 1'b1);
      end
      console_pkg::OP_REPORT:
      begin
        count = take_bits(stim_lfsr, 16);
        exp_q.push_back(`CON_ASCII_CR);
        exp_q.push_back(`CON_ASCII_LF);
        expect_text("Left:");
        div = 10000;
        for (int i = 0; i < `CON_DIGITS; i++)
        begin
          exp_q.push_back(8'("0" + (int'(count) / div) % 10));
          div = div / 10;
        end
        send_cmd(op, count, 1'b1);
      end
      console_pkg::OP_BUFFER:
      begin
        count    = take_bits(stim_lfsr, 5) % 16'd21;
        wren_exp = int'(count);
        send_cmd(op, count, 1'b0);
        for (int i = 0; i < wren_exp; i++)
        begin
          repeat (int'(take_bits(stim_lfsr, 2))) @(posedge clk);
          send_rx(8'(take_bits(stim_lfsr, 8)));
        end
      end
      default:
      begin
        send_cmd(op, '0, 1'b0);
        model_num = '0;
        keys      = int'(take_bits(stim_lfsr, 4)) + 1;
        for (int i = 0; i < keys; i++)
        begin
          if (take_bits(stim_lfsr, 1) == 16'd1)
            b = hex_chars[int'(take_bits(stim_lfsr, 5)) % 22];
          else
            b = 8'(take_bits(stim_lfsr, 8));
          if (b == `CON_ASCII_CR)
            b = " ";
          nib = hex_nibble(b);
          if (nib[4])
          begin
            exp_q.push_back(b);
            model_num = {model_num[27:0], nib[3:0]};
            t0        = tx_cnt;
            send_rx(b);
            while (tx_cnt == t0)
              @(posedge clk);
            while (!i_tx_done)
              @(posedge clk);  // Echo ends with this done pulse
          end
          else
            send_rx(b);
        end
        send_rx(`CON_ASCII_CR);
      end
    endcase
    while (done_cnt == done_start)
      @(posedge clk);
    finish_cmd(n, wren_exp, wren_start);
  endtask

  initial
  begin
    clk         = 1'b0;
    rst         = 1'b1;
    i_cmd       = '0;
    i_cmd_valid = 1'b0;
    i_rx        = '0;
    model_num   = '0;
    got_rd      = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value({29'd0, o_tx_dv, o_done, o_buf_wren}, '0, "outputs idle after reset");
    for (int n = 0; n < num_cmds; n++)
      run_cmd(n);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      done_cnt <= 0;
      wren_cnt <= 0;
    end
    else
    begin
      if (o_done)
        done_cnt <= done_cnt + 1;
      if (o_buf_wren)
        wren_cnt <= wren_cnt + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // UART transmitter stand-in, done after 0 to 7 cycles
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    logic [2:0] d;
    i_tx_done <= 1'b0;
    if (rst)
    begin
      tx_busy  <= 1'b0;
      tx_wait  <= '0;
      tx_cnt   <= 0;
      tx_early <= 0;
    end
    else if (o_tx_dv)
    begin
      if (tx_busy)
        tx_early <= tx_early + 1;
      got_q.push_back(o_tx_byte);
      tx_cnt <= tx_cnt + 1;
      d = 3'(take_bits(tx_lfsr, 3));
      if (d == 3'd0)
        i_tx_done <= 1'b1;
      else
      begin
        tx_busy <= 1'b1;
        tx_wait <= d;
      end
    end
    else if (tx_busy)
    begin
      tx_wait <= tx_wait - 3'd1;
      if (tx_wait == 3'd1)
      begin
        i_tx_done <= 1'b1;
        tx_busy   <= 1'b0;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles (%0d errors so far)",
               cycle_limit, errors);
      $display("TEST FAIL");
      $finish;
    end
  end

endmodule

/* tb.f */
+incdir+design
design/console_pkg.sv
design/msg_rom.sv
design/msg_sender.sv
design/bcd_digit_cell.sv
design/bcd_shift_ctrl.sv
design/console_seq.sv
design/uart_console.sv
verif/uart_console_props.sv
verif/uart_console_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the UART console testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module uart_console_tb
out=$(./obj_dir/Vuart_console_tb 2>&1) || { echo "$out"; echo "Simulation exited with an error"; exit 1; }
echo "$out"
if echo "$out" | grep -q "^TEST PASS$"; then
  exit 0
fi
exit 1
